// File: rtl/cameraCfg_settings.svh
`ifndef CAMERA_CFG_SETTINGS_SVH
`define CAMERA_CFG_SETTINGS_SVH

// OV5640 SCCB write address, 0x3C shifted left with write bit
`define CFG_DEV_ADDR 8'h78

`define CFG_SCCB_DIV 4 // Clocks per quarter bit

`define CFG_QUEUE_DEPTH 4 // Pending writes between sequencer and bus

// Idle clocks after soft reset, scaled down from 5 ms
`define CFG_SETTLE_CYCLES 256

`define CFG_TABLE_LEN 24 // Entries in config table

`endif

// File: rtl/cameraCfgPkg.sv
`default_nettype none

package cameraCfgPkg;

	// One sensor register write as it moves from table to bus
	typedef struct packed {
		logic [15:0] regAddr; // Register address, high byte sent first
		logic [7:0] regData; // Value written
		logic settle; // Hold the bus idle after this write
		logic last; // Final entry of the table
	} regWrite_t;

endpackage

`default_nettype wire

// File: rtl/ov5640ConfigTable.sv
`timescale 1ns/1ps
`default_nettype none

`include "cameraCfg_settings.svh"

module ov5640ConfigTable import cameraCfgPkg::*;
(
	input wire logic [7:0] index, // Table position
	output regWrite_t entry // Register write at that position
);

	logic [23:0] word; // Address and data as one word

	always_comb
	begin
		case (index)
			8'd0: word = 24'h310311; // Clock from pad
			8'd1: word = 24'h300882; // Soft reset, needs settle time
			8'd2: word = 24'h300842; // Soft power down
			8'd3: word = 24'h310303; // Clock from PLL
			8'd4: word = 24'h3017ff; // FREX, VSYNC, HREF, PCLK, D[9:6] out
			8'd5: word = 24'h3018ff; // D[5:0] and GPIO out
			8'd6: word = 24'h303713; // PLL root and pre-divider
			8'd7: word = 24'h310801; // PCLK and SCLK root dividers
			8'd8: word = 24'h300e58; // MIPI off, DVP on
			8'd9: word = 24'h430030; // YUV422 YUYV
			8'd10: word = 24'h501f00; // ISP in YUV mode
			8'd11: word = 24'h303541; // PLL for 720p
			8'd12: word = 24'h303669; // PLL multiplier
			8'd13: word = 24'h380805; // Output width high
			8'd14: word = 24'h380900; // Output width low, 1280
			8'd15: word = 24'h380a02; // Output height high
			8'd16: word = 24'h380bd0; // Output height low, 720
			8'd17: word = 24'h380c07; // HTS high
			8'd18: word = 24'h380d64; // HTS low
			8'd19: word = 24'h380e02; // VTS high
			8'd20: word = 24'h380fe4; // VTS low
			8'd21: word = 24'h381304; // Vertical offset
			8'd22: word = 24'h382404; // PCLK manual divider
			8'd23: word = 24'h300802; // Wake up from standby
			default: word = 24'h000000; // Past the end
		endcase

		entry.regAddr = word[23:8];
		entry.regData = word[7:0];
		// Only the soft reset entry waits afterwards
		entry.settle = (index == 8'd1);
		entry.last = (index == 8'(`CFG_TABLE_LEN - 1)); // Zero beyond the table too
	end

endmodule

`default_nettype wire

// File: rtl/configSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module configSequencer import cameraCfgPkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire logic start, // Begin a table run
	input wire logic full, // Queue cannot take more
	input wire logic done, // Writer finished the last entry
	output logic push, // Write pushData into queue
	output regWrite_t pushData,
	output logic busy // Run in progress
);

	logic [7:0] index; // Next table entry to push
	logic active; // Still entries left to push
	regWrite_t entry;

	ov5640ConfigTable ov5640ConfigTable_inst
	(
		.index(index),
		.entry(entry)
	);

	assign push = active && !full; // Stall on back-pressure
	assign pushData = entry;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			index <= 8'd0;
			active <= 1'b0;
			busy <= 1'b0;
		end
		else if (start && !busy)
		begin
			index <= 8'd0; // Always replay from the top
			active <= 1'b1;
			busy <= 1'b1;
		end
		else
		begin
			if (push)
			begin
				if (entry.last)
					active <= 1'b0; // Table exhausted
				else
					index <= index + 8'd1;
			end
			if (done)
				busy <= 1'b0; // Falls the cycle after done
		end
	end

endmodule

`default_nettype wire

// File: rtl/writeQueue.sv
`timescale 1ns/1ps
`default_nettype none

`include "cameraCfg_settings.svh"

module writeQueue import cameraCfgPkg::*;
#(
	parameter int DEPTH = `CFG_QUEUE_DEPTH // Power of two
)
(
	input wire logic clk,
	input wire logic rst,
	input wire logic push,
	input wire regWrite_t pushData,
	input wire logic pop,
	output regWrite_t head, // Oldest entry, valid while not empty
	output logic full,
	output logic empty
);

	localparam int PTRW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNTW = $clog2(DEPTH + 1);

	regWrite_t mem [DEPTH];
	logic [PTRW-1:0] wrPtr;
	logic [PTRW-1:0] rdPtr;
	logic [CNTW-1:0] count; // Entries held
	logic wrEn;
	logic rdEn;

	assign wrEn = push && !full; // Overflow guard
	assign rdEn = pop && !empty;
	assign head = mem[rdPtr]; // Fall-through read
	assign full = (count == CNTW'(DEPTH));
	assign empty = (count == '0);

	always_ff @(posedge clk)
	begin
		if (wrEn)
			mem[wrPtr] <= pushData;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (wrEn)
				wrPtr <= (wrPtr == PTRW'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
			if (rdEn)
				rdPtr <= (rdPtr == PTRW'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			if (wrEn && !rdEn)
				count <= count + 1'b1;
			else if (rdEn && !wrEn)
				count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: rtl/sccbWriter.sv
`timescale 1ns/1ps
`default_nettype none

`include "cameraCfg_settings.svh"

module sccbWriter import cameraCfgPkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire logic start, // Run start, clears nackSeen
	input wire logic empty,
	input wire regWrite_t head,
	output logic pop, // Take head from queue
	output logic sioc, // SCCB clock
	output logic siodOe, // High pulls SIOD low
	input wire logic siodIn, // Resolved SIOD level
	output logic done, // After stop of the last entry
	output logic nackSeen // Sticky missing acknowledge
);

	localparam int DIVW = $clog2(`CFG_SCCB_DIV) + 1;
	localparam int SETW = $clog2(`CFG_SETTLE_CYCLES) + 1;

	typedef enum logic [2:0] {stIdle, stStart, stBits, stStop, stSettle} state_t;

	state_t state;
	logic [DIVW-1:0] divCnt; // Quarter-bit divider
	logic tick; // End of a quarter bit
	logic [1:0] qtr; // Quarter within bit or condition
	logic [3:0] bitCnt; // 0..7 data, 8 acknowledge
	logic [1:0] frame; // Byte within transaction
	logic [31:0] shiftReg; // Device, address high, address low, data
	logic [SETW-1:0] settleCnt;
	logic curSettle; // Flags of the write on the bus
	logic curLast;
	logic running; // Tracks the run for start filtering

	assign tick = (divCnt == DIVW'(`CFG_SCCB_DIV - 1));
	assign pop = (state == stIdle) && !empty; // Grab next write when free

	always_ff @(posedge clk)
	begin
		if (rst || state == stIdle || state == stSettle)
			divCnt <= '0; // Realign to the transaction
		else if (tick)
			divCnt <= '0;
		else
			divCnt <= divCnt + 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= stIdle;
			qtr <= 2'd0;
			bitCnt <= 4'd0;
			frame <= 2'd0;
			settleCnt <= '0;
			sioc <= 1'b1; // Bus idles high
			siodOe <= 1'b0;
			done <= 1'b0;
			nackSeen <= 1'b0;
			running <= 1'b0;
		end
		else
		begin
			done <= 1'b0; // Single-cycle pulse
			if (start && !running)
			begin
				running <= 1'b1;
				nackSeen <= 1'b0;
			end
			else if (done)
				running <= 1'b0; // In step with sequencer busy
			case (state)
				stIdle:
				begin
					qtr <= 2'd0;
					if (!empty)
					begin
						shiftReg <= {`CFG_DEV_ADDR, head.regAddr, head.regData};
						curSettle <= head.settle;
						curLast <= head.last;
						state <= stStart;
					end
				end
				stStart:
				begin
					if (tick)
					begin
						qtr <= qtr + 2'd1;
						case (qtr)
							2'd0: siodOe <= 1'b1; // SIOD falls, SIOC high
							2'd1: sioc <= 1'b0;
							2'd3:
							begin
								bitCnt <= 4'd0;
								frame <= 2'd0;
								state <= stBits;
							end
							default: ;
						endcase
					end
				end
				stBits:
				begin
					if (tick)
					begin
						qtr <= qtr + 2'd1;
						case (qtr)
							// Data moves only with SIOC low; release for acknowledge
							2'd0: siodOe <= (bitCnt == 4'd8) ? 1'b0 : !shiftReg[31];
							2'd1: sioc <= 1'b1;
							2'd2:
							begin
								if (bitCnt == 4'd8 && siodIn)
									nackSeen <= 1'b1; // Sensor left line high
							end
							default:
							begin
								sioc <= 1'b0;
								if (bitCnt == 4'd8)
								begin
									bitCnt <= 4'd0;
									frame <= frame + 2'd1;
									if (frame == 2'd3)
										state <= stStop; // Data byte done
								end
								else
								begin
									bitCnt <= bitCnt + 4'd1;
									shiftReg <= {shiftReg[30:0], 1'b0}; // MSB first
								end
							end
						endcase
					end
				end
				stStop:
				begin
					if (tick)
					begin
						qtr <= qtr + 2'd1;
						case (qtr)
							2'd0: siodOe <= 1'b1; // SIOD low under SIOC low
							2'd1: sioc <= 1'b1;
							2'd2: siodOe <= 1'b0; // SIOD rises, stop
							default:
							begin
								settleCnt <= '0;
								if (curSettle)
									state <= stSettle;
								else
								begin
									state <= stIdle;
									done <= curLast;
								end
							end
						endcase
					end
				end
				stSettle:
				begin
					if (settleCnt == SETW'(`CFG_SETTLE_CYCLES - 1))
					begin
						state <= stIdle;
						done <= curLast;
					end
					else
						settleCnt <= settleCnt + 1'b1; // Sensor recovers from reset
				end
				default: state <= stIdle;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/cameraConfigTop.sv
`timescale 1ns/1ps
`default_nettype none

module cameraConfigTop import cameraCfgPkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire logic start, // Kick off the register table
	output logic sioc,
	output logic siodOe, // Open-drain pull-down enable
	input wire logic siodIn,
	output logic busy,
	output logic done,
	output logic nackSeen
);

	logic push;
	logic pop;
	logic full;
	logic empty;
	regWrite_t pushData; // Sequencer to queue
	regWrite_t head; // Queue to writer

	configSequencer configSequencer_inst
	(
		.clk(clk),
		.rst(rst),
		.start(start),
		.full(full),
		.done(done),
		.push(push),
		.pushData(pushData),
		.busy(busy)
	);

	writeQueue writeQueue_inst
	(
		.clk(clk),
		.rst(rst),
		.push(push),
		.pushData(pushData),
		.pop(pop),
		.head(head),
		.full(full),
		.empty(empty)
	);

	sccbWriter sccbWriter_inst
	(
		.clk(clk),
		.rst(rst),
		.start(start),
		.empty(empty),
		.head(head),
		.pop(pop),
		.sioc(sioc),
		.siodOe(siodOe),
		.siodIn(siodIn),
		.done(done),
		.nackSeen(nackSeen)
	);

endmodule

`default_nettype wire

// File: testbench/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen
(
	output logic clk,
	output logic rst
);

	logic rstReg = 1'b1; // Held from time zero

	assign rst = rstReg;

	initial
	begin
		clk = 1'b0;
		forever #5 clk = !clk; // 10 ns period
	end

	initial
	begin
		repeat (3) @(posedge clk);
		rstReg <= 1'b0; // Released on the third edge
	end

endmodule

`default_nettype wire

// File: testbench/sccbSensorModel.sv
`timescale 1ns/1ps
`default_nettype none

module sccbSensorModel
(
	input wire logic clk,
	input wire logic rst,
	input wire logic sioc,
	input wire logic siodOe, // DUT pulls SIOD low
	input wire logic signed [31:0] nackTxn, // Transaction whose data acknowledge is withheld
	output logic siodIn, // Resolved line with pull-up
	output logic txnStrobe, // Stop after four complete frames
	output logic [31:0] txnWord, // Device, address high, address low, data
	output logic startSeen
);

	logic ackPull; // Sensor drives acknowledge
	logic sclQ;
	logic sdaQ;
	logic [3:0] bitCnt; // SCL rises within frame
	logic [2:0] frame;
	logic [31:0] shiftIn;
	int txnCount; // Transactions since time zero

	// Line floats high unless someone pulls it
	assign siodIn = !((siodOe === 1'b1) || (ackPull === 1'b1));

	always @(posedge clk)
	begin
		if (rst)
		begin
			ackPull <= 1'b0;
			sclQ <= 1'b1;
			sdaQ <= 1'b1;
			bitCnt <= 4'd0;
			frame <= 3'd0;
			shiftIn <= 32'd0;
			txnCount <= 0;
			txnStrobe <= 1'b0;
			txnWord <= 32'd0;
			startSeen <= 1'b0;
		end
		else
		begin
			sclQ <= sioc;
			sdaQ <= siodIn;
			txnStrobe <= 1'b0;
			startSeen <= 1'b0;
			if (sclQ && sioc && sdaQ && !siodIn)
			begin
				bitCnt <= 4'd0; // Start, SDA falls under SCL high
				frame <= 3'd0;
				startSeen <= 1'b1;
			end
			else if (sclQ && sioc && !sdaQ && siodIn)
			begin
				if (frame == 3'd4) // Stop after a full write
				begin
					txnStrobe <= 1'b1;
					txnWord <= shiftIn;
					txnCount <= txnCount + 1;
				end
				frame <= 3'd0;
			end
			else if (!sclQ && sioc && frame != 3'd4) // Stop's SCL rise carries no bit
			begin
				if (bitCnt == 4'd8)
				begin
					bitCnt <= 4'd0; // Acknowledge clocked
					frame <= frame + 3'd1;
				end
				else
				begin
					bitCnt <= bitCnt + 4'd1;
					shiftIn <= {shiftIn[30:0], siodIn}; // MSB first
				end
			end
			else if (sclQ && !sioc)
				// Pull low for the ninth bit only
				ackPull <= (bitCnt == 4'd8) && !(txnCount == nackTxn && frame == 3'd3);
		end
	end

endmodule

`default_nettype wire

// File: testbench/cameraConfigTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cameraCfg_settings.svh"

module cameraConfigTb;

	// One run of ~40 bit times per write plus the settle wait
	localparam int RUN_CYCLES = `CFG_TABLE_LEN * 40 * 16 + `CFG_SETTLE_CYCLES;
	localparam int MAX_CYCLES = 2 * (3 * RUN_CYCLES + 3 * 96) + 5000; // About 100000
	localparam int SETTLE_IDX = 1; // Software reset entry

	localparam logic [23:0] EXPECTED [`CFG_TABLE_LEN] = '{
		24'h310311, 24'h300882, 24'h300842, 24'h310303,
		24'h3017ff, 24'h3018ff, 24'h303713, 24'h310801,
		24'h300e58, 24'h430030, 24'h501f00, 24'h303541,
		24'h303669, 24'h380805, 24'h380900, 24'h380a02,
		24'h380bd0, 24'h380c07, 24'h380d64, 24'h380e02,
		24'h380fe4, 24'h381304, 24'h382404, 24'h300802
	};

	logic clk;
	logic rst;
	logic start = 1'b0;
	logic sioc;
	logic siodOe;
	logic siodIn;
	logic busy;
	logic done;
	logic nackSeen;
	logic txnStrobe;
	logic startSeen;
	logic [31:0] txnWord;
	int nackTxn = -1; // No withheld acknowledge
	logic [15:0] lfsr = 16'd68;
	int cycleCount = 0;
	int runTxn = 0; // Writes seen in the current run
	int doneCount = 0;
	int stopCycle = 0;
	bit settleArmed = 1'b0;
	bit nackPrev = 1'b0;
	bit startPrev = 1'b0;
	int monErrors = 0; // Bus monitor failures
	int seqErrors = 0; // Stimulus-side failures
	int testNum = 0;
	int failedTests = 0;
	int lastTotal = 0;

	clockGen clockGen_inst
	(
		.clk(clk),
		.rst(rst)
	);

	sccbSensorModel sccbSensorModel_inst
	(
		.clk(clk),
		.rst(rst),
		.sioc(sioc),
		.siodOe(siodOe),
		.nackTxn(nackTxn),
		.siodIn(siodIn),
		.txnStrobe(txnStrobe),
		.txnWord(txnWord),
		.startSeen(startSeen)
	);

	cameraConfigTop cameraConfigTop_inst
	(
		.clk(clk),
		.rst(rst),
		.start(start),
		.sioc(sioc),
		.siodOe(siodOe),
		.siodIn(siodIn),
		.busy(busy),
		.done(done),
		.nackSeen(nackSeen)
	);

	function automatic logic [15:0] lfsrStep(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1); // Galois, 16-bit
	endfunction

	task automatic drawBits(input int nBits, output int value);
		value = 0;
		for (int i = 0; i < nBits; i++)
		begin
			lfsr = lfsrStep(lfsr); // One step per bit
			value = (value << 1) | int'(lfsr[0]);
		end
	endtask

	function automatic bit sameValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
			$display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
		return got === exp;
	endfunction

	task automatic finishTest(input string name);
		int total;
		total = seqErrors + monErrors;
		testNum++;
		if (total == lastTotal)
			$display("Test %0d, %s: ok", testNum, name);
		else
		begin
			failedTests++;
			$display("Test %0d, %s: %0d errors", testNum, name, total - lastTotal);
		end
		lastTotal = total;
	endtask

	// Start pulse, optional ignored restart, then wait for done
	task automatic runTable(input bit extraStart);
		int delay;
		drawBits(4, delay);
		repeat (delay + 2) @(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		@(posedge clk);
		assert (sameValue("busy", 32'(busy), 32'd1)) else seqErrors++;
		assert (sameValue("nackSeen", 32'(nackSeen), 32'd0)) else seqErrors++;
		if (extraStart)
		begin
			while (nackSeen !== 1'b1)
				@(posedge clk); // Restart only once the missed acknowledge is flagged
			drawBits(3, delay);
			repeat (delay + 1) @(posedge clk);
			start <= 1'b1; // Lands mid-run
			@(posedge clk);
			start <= 1'b0;
			@(posedge clk);
			assert (sameValue("busy", 32'(busy), 32'd1)) else seqErrors++;
			assert (sameValue("nackSeen", 32'(nackSeen), 32'd1)) else seqErrors++;
		end
		do
			@(posedge clk);
		while (done !== 1'b1);
		@(posedge clk);
		assert (sameValue("busy", 32'(busy), 32'd0)) else seqErrors++; // Cycle after done
		repeat (16) @(posedge clk);
		assert (sameValue("transaction count", runTxn, `CFG_TABLE_LEN)) else seqErrors++;
		assert (sameValue("done count", doneCount, 1)) else seqErrors++;
		assert (sameValue("busy", 32'(busy), 32'd0)) else seqErrors++;
	endtask

	// Bus monitor, compares every write against the table copy
	always @(posedge clk)
	begin
		if (!rst)
		begin
			if (start && !busy)
			begin
				runTxn = 0; // Accepted start
				doneCount = 0;
			end
			if (txnStrobe)
			begin
				assert (runTxn < `CFG_TABLE_LEN) else
				begin
					$display("Write seen after the end of the table");
					monErrors++;
				end
				if (runTxn < `CFG_TABLE_LEN)
				begin
					assert (sameValue("device", 32'(txnWord[31:24]), 32'(`CFG_DEV_ADDR)))
						else monErrors++;
					assert (sameValue("regAddr", 32'(txnWord[23:8]),
						32'(EXPECTED[5'(runTxn)][23:8]))) else monErrors++;
					assert (sameValue("regData", 32'(txnWord[7:0]),
						32'(EXPECTED[5'(runTxn)][7:0]))) else monErrors++;
				end
				if (runTxn == SETTLE_IDX)
				begin
					stopCycle = cycleCount; // Stop of the reset write
					settleArmed = 1'b1;
				end
				runTxn++;
			end
			if (startSeen && settleArmed)
			begin
				settleArmed = 1'b0;
				assert (cycleCount - stopCycle >= `CFG_SETTLE_CYCLES) else
				begin
					$display("Settle gap after reset write only %0d cycles",
						cycleCount - stopCycle);
					monErrors++;
				end
			end
			if (done)
			begin
				doneCount++;
				assert (sameValue("done count", doneCount, 1)) else monErrors++;
				assert (sameValue("writes before done", runTxn, `CFG_TABLE_LEN))
					else monErrors++;
			end
			assert (!(nackPrev && !nackSeen && !startPrev)) else
			begin
				$display("nackSeen cleared without an accepted start pulse");
				monErrors++;
			end
			nackPrev = nackSeen;
			startPrev = start && !busy; // Ignored starts must not clear it
		end
	end

	initial
	begin
		int delay;
		int pick;
		while (rst !== 1'b0)
			@(posedge clk);

		drawBits(5, delay); // Quiet bus window
		repeat (delay + 8)
		begin
			@(posedge clk);
			assert (sameValue("sioc", 32'(sioc), 32'd1)) else seqErrors++;
			assert (sameValue("siodOe", 32'(siodOe), 32'd0)) else seqErrors++;
			assert (sameValue("busy", 32'(busy), 32'd0)) else seqErrors++;
			assert (sameValue("done", 32'(done), 32'd0)) else seqErrors++;
			assert (sameValue("nackSeen", 32'(nackSeen), 32'd0)) else seqErrors++;
		end
		finishTest("idle after reset");

		runTable(1'b0);
		assert (sameValue("nackSeen", 32'(nackSeen), 32'd0)) else seqErrors++;
		finishTest("first run, table order and settle gap");

		drawBits(5, pick);
		pick = pick % `CFG_TABLE_LEN;
		nackTxn <= `CFG_TABLE_LEN + pick; // Model counts across runs
		$display("Withholding acknowledge on write %0d", pick);
		runTable(1'b1); // Restart attempt while busy and nackSeen set
		assert (sameValue("nackSeen", 32'(nackSeen), 32'd1)) else seqErrors++;
		nackTxn <= -1;
		finishTest("second run with missing acknowledge and start while busy");

		runTable(1'b0);
		assert (sameValue("nackSeen", 32'(nackSeen), 32'd0)) else seqErrors++;
		finishTest("third run replays with nackSeen cleared");

		$display("Tests run %0d, failed %0d, check errors %0d", testNum, failedTests,
			seqErrors + monErrors);
		if (seqErrors + monErrors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	// Watchdog
	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= MAX_CYCLES)
		begin
			$display("Run timed out after %0d cycles", cycleCount);
			$display("Simulation failed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: all.f
+incdir+rtl
rtl/cameraCfgPkg.sv
rtl/ov5640ConfigTable.sv
rtl/configSequencer.sv
rtl/writeQueue.sv
rtl/sccbWriter.sv
rtl/cameraConfigTop.sv
testbench/clockGen.sv
testbench/sccbSensorModel.sv
testbench/cameraConfigTb.sv

// File: sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module cameraConfigTb \
	--Mdir obj_dir -o simv
./obj_dir/simv | tee sim.log

if grep -q "Simulation completed successfully" sim.log; then
	exit 0
fi
exit 1
